/* common/vic_regs_pkg.sv */
package vic_regs_pkg;

        localparam int num_sprites = 8;
        localparam int color_w = 4;
        localparam int addr_w = 6;
        localparam int data_w = 8;
        localparam int raster_w = 9;

        // register map, 0x00-0x0f are the sprite x/y pairs
        localparam logic [addr_w-1:0] reg_sprite_x_bit_8 = 6'h10;
        localparam logic [addr_w-1:0] reg_screen_control_1 = 6'h11;
        localparam logic [addr_w-1:0] reg_raster_line = 6'h12;
        localparam logic [addr_w-1:0] reg_sprite_enable = 6'h15;
        localparam logic [addr_w-1:0] reg_screen_control_2 = 6'h16;
        localparam logic [addr_w-1:0] reg_sprite_expand_y = 6'h17;
        localparam logic [addr_w-1:0] reg_memory_setup = 6'h18;
        localparam logic [addr_w-1:0] reg_interrupt_status = 6'h19;
        localparam logic [addr_w-1:0] reg_interrupt_control = 6'h1a;
        localparam logic [addr_w-1:0] reg_sprite_priority = 6'h1b;
        localparam logic [addr_w-1:0] reg_sprite_multicolor_mode = 6'h1c;
        localparam logic [addr_w-1:0] reg_sprite_expand_x = 6'h1d;
        localparam logic [addr_w-1:0] reg_sprite_2_sprite_collision = 6'h1e;
        localparam logic [addr_w-1:0] reg_sprite_2_data_collision = 6'h1f;
        // border, then four background colors at +1..+4
        localparam logic [addr_w-1:0] reg_border_color = 6'h20;
        // multicolor 1 sits at +1
        localparam logic [addr_w-1:0] reg_sprite_multi_color_0 = 6'h25;
        // one color per sprite up to 0x2e
        localparam logic [addr_w-1:0] reg_sprite_color_0 = 6'h27;

        localparam logic [data_w-1:0] unused_read = 8'hff;
        localparam logic [data_w-color_w-1:0] color_pad = '1;

        typedef struct packed {
                logic [1:0] group;
                logic [2:0] index;
                logic y_sel;
        } sprite_addr_t;

        // flat address, or sprite index plus x/y select
        typedef union packed {
                logic [addr_w-1:0] raw;
                sprite_addr_t sprite;
        } reg_addr_u;

        typedef struct packed {
                logic [num_sprites-1:0][data_w:0] x;
                logic [num_sprites-1:0][data_w-1:0] y;
                logic [num_sprites-1:0][color_w-1:0] col;
                logic [num_sprites-1:0] en;
                logic [num_sprites-1:0] xe;
                logic [num_sprites-1:0] ye;
                logic [num_sprites-1:0] pri;
                logic [num_sprites-1:0] mmc;
                logic [color_w-1:0] mc0;
                logic [color_w-1:0] mc1;
        } sprite_cfg_t;

        typedef struct packed {
                logic [color_w-1:0] ec;
                logic [color_w-1:0] b0c;
                logic [color_w-1:0] b1c;
                logic [color_w-1:0] b2c;
                logic [color_w-1:0] b3c;
                logic [2:0] xscroll;
                logic [2:0] yscroll;
                logic csel;
                logic rsel;
                logic den;
                logic bmm;
                logic ecm;
                logic res;
                logic mcm;
                logic [2:0] cb;
                logic [3:0] vm;
                logic [raster_w-1:0] raster_irq_compare;
        } screen_cfg_t;

        typedef struct packed {
                logic erst;
                logic embc;
                logic emmc;
        } irq_cfg_t;

endpackage

/* hdl/bus_cycle.sv */
`timescale 1ns/1ns

module bus_cycle (
        input logic clk_dot4x,
        input logic rst,
        input logic aec,
        input logic ce,
        input logic rw,
        input logic phi_phase_start_dav,
        output logic rd_stb,
        output logic wr_stb
);

        logic bus_sel;
        logic access_seen;

        assign bus_sel = aec && !ce;
        // one read strobe per access, however long the cpu holds it
        assign rd_stb = bus_sel && rw && !access_seen;
        // writes land on the data-valid point of the phase
        assign wr_stb = bus_sel && !rw && phi_phase_start_dav;

        always_ff @(posedge clk_dot4x) begin
                if (rst || !bus_sel) begin
                        access_seen <= 1'b0;
                end else if (rd_stb) begin
                        access_seen <= 1'b1;
                end
        end

        strobe_exclusive: assert property (@(posedge clk_dot4x) disable iff (rst)
                !(rd_stb && wr_stb));

endmodule

/* hdl/irq_regs.sv */
`timescale 1ns/1ns

module irq_regs (
        input logic clk_dot4x,
        input logic rst,
        input logic clk_phi,
        input logic phi_phase_start_15,
        input logic phi_phase_start_1,
        input logic wr_stb,
        input logic rd_stb,
        input vic_regs_pkg::reg_addr_u adi,
        input logic [vic_regs_pkg::data_w-1:0] dbi,
        output vic_regs_pkg::irq_cfg_t irq_cfg,
        output logic irst_clr,
        output logic imbc_clr,
        output logic immc_clr,
        output logic m2m_clr,
        output logic m2d_clr
);

        import vic_regs_pkg::*;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        irq_cfg <= '0;
                        irst_clr <= 1'b0;
                        imbc_clr <= 1'b0;
                        immc_clr <= 1'b0;
                        m2m_clr <= 1'b0;
                        m2d_clr <= 1'b0;
                end else begin
                        // status clears drop at the end of the high phase
                        if (phi_phase_start_15 && clk_phi) begin
                                irst_clr <= 1'b0;
                                imbc_clr <= 1'b0;
                                immc_clr <= 1'b0;
                        end
                        // collision clears drop early in the next low phase
                        if (phi_phase_start_1 && !clk_phi) begin
                                m2m_clr <= 1'b0;
                                m2d_clr <= 1'b0;
                        end
                        // set after release so a same-cycle set wins
                        if (wr_stb && adi.raw == reg_interrupt_status) begin
                                irst_clr <= dbi[0];
                                imbc_clr <= dbi[1];
                                immc_clr <= dbi[2];
                        end
                        if (wr_stb && adi.raw == reg_interrupt_control) begin
                                irq_cfg.erst <= dbi[0];
                                irq_cfg.embc <= dbi[1];
                                irq_cfg.emmc <= dbi[2];
                        end
                        if (rd_stb && adi.raw == reg_sprite_2_sprite_collision) begin
                                m2m_clr <= 1'b1;
                        end
                        if (rd_stb && adi.raw == reg_sprite_2_data_collision) begin
                                m2d_clr <= 1'b1;
                        end
                end
        end

        irst_clr_released: assert property (@(posedge clk_dot4x) disable iff (rst)
                (phi_phase_start_15 && clk_phi && !wr_stb) |=> !irst_clr);

endmodule

/* hdl/read_data.sv */
`timescale 1ns/1ns

module read_data (
        input logic clk_dot4x,
        input logic rd_stb,
        input vic_regs_pkg::reg_addr_u adi,
        input vic_regs_pkg::sprite_cfg_t sprite_cfg,
        input vic_regs_pkg::screen_cfg_t screen_cfg,
        input vic_regs_pkg::irq_cfg_t irq_cfg,
        input logic [vic_regs_pkg::raster_w-1:0] raster_line,
        input logic irq,
        input logic immc,
        input logic imbc,
        input logic irst,
        input logic [vic_regs_pkg::num_sprites-1:0] sprite_m2m,
        input logic [vic_regs_pkg::num_sprites-1:0] sprite_m2d,
        output logic [vic_regs_pkg::data_w-1:0] dbo
);

        import vic_regs_pkg::*;

        logic [addr_w-1:0] col_off;
        logic [data_w-1:0] rd_byte;

        assign col_off = adi.raw - reg_sprite_color_0;

        always_comb begin
                rd_byte = unused_read;
                if (adi.sprite.group == 2'd0) begin
                        if (adi.sprite.y_sel) begin
                                rd_byte = sprite_cfg.y[adi.sprite.index];
                        end else begin
                                rd_byte = sprite_cfg.x[adi.sprite.index][data_w-1:0];
                        end
                end else begin
                        case (adi.raw)
                                reg_sprite_x_bit_8: begin
                                        for (int n = 0; n < num_sprites; n++) begin
                                                rd_byte[n] = sprite_cfg.x[n][data_w];
                                        end
                                end
                                // live raster line, not the compare value
                                reg_screen_control_1: begin
                                        rd_byte = {raster_line[raster_w-1], screen_cfg.ecm,
                                                   screen_cfg.bmm, screen_cfg.den,
                                                   screen_cfg.rsel, screen_cfg.yscroll};
                                end
                                reg_raster_line: rd_byte = raster_line[data_w-1:0];
                                reg_sprite_enable: rd_byte = sprite_cfg.en;
                                reg_screen_control_2: begin
                                        rd_byte = {2'b11, screen_cfg.res, screen_cfg.mcm,
                                                   screen_cfg.csel, screen_cfg.xscroll};
                                end
                                reg_sprite_expand_y: rd_byte = sprite_cfg.ye;
                                reg_memory_setup: begin
                                        rd_byte = {screen_cfg.vm, screen_cfg.cb, 1'b1};
                                end
                                // irq arrives already inverted, light pen slot reads 1
                                reg_interrupt_status: begin
                                        rd_byte = {irq, 3'b111, 1'b1, immc, imbc, irst};
                                end
                                reg_interrupt_control: begin
                                        rd_byte = {4'b1111, 1'b1, irq_cfg.emmc, irq_cfg.embc,
                                                   irq_cfg.erst};
                                end
                                reg_sprite_priority: rd_byte = sprite_cfg.pri;
                                reg_sprite_multicolor_mode: rd_byte = sprite_cfg.mmc;
                                reg_sprite_expand_x: rd_byte = sprite_cfg.xe;
                                reg_sprite_2_sprite_collision: rd_byte = sprite_m2m;
                                reg_sprite_2_data_collision: rd_byte = sprite_m2d;
                                reg_border_color: rd_byte = {color_pad, screen_cfg.ec};
                                reg_border_color + 6'd1: rd_byte = {color_pad, screen_cfg.b0c};
                                reg_border_color + 6'd2: rd_byte = {color_pad, screen_cfg.b1c};
                                reg_border_color + 6'd3: rd_byte = {color_pad, screen_cfg.b2c};
                                reg_border_color + 6'd4: rd_byte = {color_pad, screen_cfg.b3c};
                                reg_sprite_multi_color_0: rd_byte = {color_pad, sprite_cfg.mc0};
                                reg_sprite_multi_color_0 + 6'd1: begin
                                        rd_byte = {color_pad, sprite_cfg.mc1};
                                end
                                default: begin
                                        if (col_off < addr_w'(num_sprites)) begin
                                                rd_byte = {color_pad,
                                                           sprite_cfg.col[col_off[2:0]]};
                                        end
                                end
                        endcase
                end
        end

        // held until the next access starts
        always_ff @(posedge clk_dot4x) begin
                if (rd_stb) begin
                        dbo <= rd_byte;
                end
        end

endmodule

/* hdl/screen_regs.sv */
`timescale 1ns/1ns

module screen_regs (
        input logic clk_dot4x,
        input logic wr_stb,
        input vic_regs_pkg::reg_addr_u adi,
        input logic [vic_regs_pkg::data_w-1:0] dbi,
        output vic_regs_pkg::screen_cfg_t screen_cfg
);

        import vic_regs_pkg::*;

        always_ff @(posedge clk_dot4x) begin
                if (wr_stb) begin
                        case (adi.raw)
                                reg_screen_control_1: begin
                                        screen_cfg.yscroll <= dbi[2:0];
                                        screen_cfg.rsel <= dbi[3];
                                        screen_cfg.den <= dbi[4];
                                        screen_cfg.bmm <= dbi[5];
                                        screen_cfg.ecm <= dbi[6];
                                        // compare bit 8 rides in the top bit
                                        screen_cfg.raster_irq_compare[raster_w-1] <= dbi[7];
                                end
                                reg_raster_line: begin
                                        screen_cfg.raster_irq_compare[data_w-1:0] <= dbi;
                                end
                                reg_screen_control_2: begin
                                        screen_cfg.xscroll <= dbi[2:0];
                                        screen_cfg.csel <= dbi[3];
                                        screen_cfg.mcm <= dbi[4];
                                        screen_cfg.res <= dbi[5];
                                end
                                reg_memory_setup: begin
                                        screen_cfg.cb <= dbi[3:1];
                                        screen_cfg.vm <= dbi[7:4];
                                end
                                reg_border_color: screen_cfg.ec <= dbi[color_w-1:0];
                                reg_border_color + 6'd1: screen_cfg.b0c <= dbi[color_w-1:0];
                                reg_border_color + 6'd2: screen_cfg.b1c <= dbi[color_w-1:0];
                                reg_border_color + 6'd3: screen_cfg.b2c <= dbi[color_w-1:0];
                                reg_border_color + 6'd4: screen_cfg.b3c <= dbi[color_w-1:0];
                                default: ;
                        endcase
                end
        end

endmodule

/* hdl/vic_registers.sv */
`timescale 1ns/1ns

module vic_registers (
        input logic clk_dot4x,
        input logic rst,
        input logic clk_phi,
        input logic phi_phase_start_15,
        input logic phi_phase_start_1,
        input logic phi_phase_start_dav,
        input logic ce,
        input logic rw,
        input logic aec,
        input vic_regs_pkg::reg_addr_u adi,
        input logic [vic_regs_pkg::data_w-1:0] dbi,
        input logic [vic_regs_pkg::raster_w-1:0] raster_line,
        input logic irq,
        input logic immc,
        input logic imbc,
        input logic irst,
        input logic [vic_regs_pkg::num_sprites-1:0] sprite_m2m,
        input logic [vic_regs_pkg::num_sprites-1:0] sprite_m2d,
        output logic [vic_regs_pkg::data_w-1:0] dbo,
        output vic_regs_pkg::sprite_cfg_t sprite_cfg,
        output vic_regs_pkg::screen_cfg_t screen_cfg,
        output vic_regs_pkg::irq_cfg_t irq_cfg,
        output logic irst_clr,
        output logic imbc_clr,
        output logic immc_clr,
        output logic m2m_clr,
        output logic m2d_clr
);

        logic rd_stb;
        logic wr_stb;

        bus_cycle bus_cycle_i (
                .clk_dot4x, .rst, .aec, .ce, .rw, .phi_phase_start_dav,
                .rd_stb, .wr_stb
        );

        sprite_regs sprite_regs_i (
                .clk_dot4x, .wr_stb, .adi, .dbi, .sprite_cfg
        );

        screen_regs screen_regs_i (
                .clk_dot4x, .wr_stb, .adi, .dbi, .screen_cfg
        );

        irq_regs irq_regs_i (
                .clk_dot4x, .rst, .clk_phi, .phi_phase_start_15, .phi_phase_start_1,
                .wr_stb, .rd_stb, .adi, .dbi, .irq_cfg,
                .irst_clr, .imbc_clr, .immc_clr, .m2m_clr, .m2d_clr
        );

        read_data read_data_i (
                .clk_dot4x, .rd_stb, .adi, .sprite_cfg, .screen_cfg, .irq_cfg,
                .raster_line, .irq, .immc, .imbc, .irst, .sprite_m2m, .sprite_m2d,
                .dbo
        );

endmodule

/* sprite/sprite_regs.sv */
`timescale 1ns/1ns

module sprite_regs (
        input logic clk_dot4x,
        input logic wr_stb,
        input vic_regs_pkg::reg_addr_u adi,
        input logic [vic_regs_pkg::data_w-1:0] dbi,
        output vic_regs_pkg::sprite_cfg_t sprite_cfg
);

        import vic_regs_pkg::*;

        logic [addr_w-1:0] col_off;

        // wraps for addresses below the color block
        assign col_off = adi.raw - reg_sprite_color_0;

        always_ff @(posedge clk_dot4x) begin
                if (wr_stb) begin
                        // x low byte on even, y on odd addresses
                        if (adi.sprite.group == 2'd0) begin
                                if (adi.sprite.y_sel) begin
                                        sprite_cfg.y[adi.sprite.index] <= dbi;
                                end else begin
                                        sprite_cfg.x[adi.sprite.index][data_w-1:0] <= dbi;
                                end
                        end
                        case (adi.raw)
                                reg_sprite_x_bit_8: begin
                                        for (int n = 0; n < num_sprites; n++) begin
                                                sprite_cfg.x[n][data_w] <= dbi[n];
                                        end
                                end
                                reg_sprite_enable: sprite_cfg.en <= dbi;
                                reg_sprite_expand_y: sprite_cfg.ye <= dbi;
                                reg_sprite_priority: sprite_cfg.pri <= dbi;
                                reg_sprite_multicolor_mode: sprite_cfg.mmc <= dbi;
                                reg_sprite_expand_x: sprite_cfg.xe <= dbi;
                                reg_sprite_multi_color_0: sprite_cfg.mc0 <= dbi[color_w-1:0];
                                reg_sprite_multi_color_0 + 6'd1: begin
                                        sprite_cfg.mc1 <= dbi[color_w-1:0];
                                end
                                default: ;
                        endcase
                        if (col_off < addr_w'(num_sprites)) begin
                                sprite_cfg.col[col_off[2:0]] <= dbi[color_w-1:0];
                        end
                end
        end

endmodule

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// last byte written to each address
logic [7:0] shadow_regs [64];

// read byte for addr, using the status inputs as driven right now
function automatic logic [7:0] expected_read(input logic [5:0] addr);
        logic [7:0] w;
        logic [7:0] r;
        w = shadow_regs[addr];
        r = 8'hff;
        if (addr <= 6'h10) begin
                r = w;
        end else begin
                case (addr)
                        6'h11: r = {raster_line[8], w[6:0]};
                        6'h12: r = raster_line[7:0];
                        6'h15, 6'h17, 6'h1b, 6'h1c, 6'h1d: r = w;
                        6'h16: r = {2'b11, w[5:0]};
                        6'h18: r = {w[7:1], 1'b1};
                        // light pen slot stays set
                        6'h19: r = {irq, 4'b1111, immc, imbc, irst};
                        6'h1a: r = {5'b11111, w[2:0]};
                        6'h1e: r = sprite_m2m;
                        6'h1f: r = sprite_m2d;
                        default: begin
                                // colors, upper nibble reads as ones
                                if (addr >= 6'h20 && addr <= 6'h2e) begin
                                        r = {4'hf, w[3:0]};
                                end
                        end
                endcase
        end
        return r;
endfunction

`endif

/* testbench/tb_vic_registers.sv */
`timescale 1ns/1ns

module tb_vic_registers;

        localparam int at_dav = 0;
        localparam int at_high_15 = 1;
        localparam int at_low_1 = 2;

        logic clk_dot4x;
        logic rst;
        logic [4:0] phase_cnt;
        logic clk_phi;
        logic phi_phase_start_15;
        logic phi_phase_start_1;
        logic phi_phase_start_dav;
        logic ce;
        logic rw;
        logic aec;
        vic_regs_pkg::reg_addr_u adi;
        logic [7:0] dbi;
        logic [8:0] raster_line;
        logic irq;
        logic immc;
        logic imbc;
        logic irst;
        logic [7:0] sprite_m2m;
        logic [7:0] sprite_m2d;
        logic [7:0] dbo;
        vic_regs_pkg::sprite_cfg_t sprite_cfg;
        vic_regs_pkg::screen_cfg_t screen_cfg;
        vic_regs_pkg::irq_cfg_t irq_cfg;
        logic irst_clr;
        logic imbc_clr;
        logic immc_clr;
        logic m2m_clr;
        logic m2d_clr;
        logic chk_req;
        logic [5:0] chk_addr;
        logic [7:0] chk_exp;
        int error_count;
        int seed_val;

        `include "tb_model.svh"

        vic_registers dut_i (.*);

        initial begin
                clk_dot4x = 1'b0;
                forever #50 clk_dot4x = ~clk_dot4x;
        end

        // strobes follow the position within each 16-cycle phi half
        assign clk_phi = phase_cnt[4];
        assign phi_phase_start_1 = (phase_cnt[3:0] == 4'd1);
        assign phi_phase_start_15 = (phase_cnt[3:0] == 4'd15);
        assign phi_phase_start_dav = clk_phi && (phase_cnt[3:0] == 4'd6);

        initial begin
                phase_cnt = '0;
                forever begin
                        @(posedge clk_dot4x);
                        #5;
                        phase_cnt = phase_cnt + 5'd1;
                end
        end

        task automatic stop_run();
                error_count++;
                $display("Finished with errors");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic check_value(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
                assert (got === exp) else begin
                        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
                        stop_run();
                end
        endtask

        // dbo sampled before the edge updates it
        initial begin
                forever begin
                        @(posedge clk_dot4x);
                        if (chk_req) begin
                                check_value($sformatf("dbo at address %h", chk_addr), dbo, chk_exp);
                        end
                end
        end

        task automatic next_drive_point();
                @(posedge clk_dot4x);
                #5;
        endtask

        // returns on the edge that samples the wanted strobe
        task automatic wait_for_phase(input int kind, input string what);
                logic hit;
                int t;
                hit = 1'b0;
                t = 0;
                while (!hit && t < 40) begin
                        @(posedge clk_dot4x);
                        case (kind)
                                at_dav: hit = phi_phase_start_dav;
                                at_high_15: hit = phi_phase_start_15 && clk_phi;
                                default: hit = phi_phase_start_1 && !clk_phi;
                        endcase
                        t++;
                end
                assert (hit) else begin
                        $display("timed out waiting for %s", what);
                        stop_run();
                end
        endtask

        task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
                adi.raw = addr;
                dbi = data;
                aec = 1'b1;
                ce = 1'b0;
                rw = 1'b0;
                wait_for_phase(at_dav, "the data-valid strobe of a write");
                #5;
                aec = 1'b0;
                ce = 1'b1;
                rw = 1'b1;
                shadow_regs[addr] = data;
        endtask

        task automatic read_start(input logic [5:0] addr, output logic [7:0] exp);
                adi.raw = addr;
                aec = 1'b1;
                ce = 1'b0;
                rw = 1'b1;
                exp = expected_read(addr);
        endtask

        task automatic check_dbo(input logic [5:0] addr, input logic [7:0] exp);
                chk_addr = addr;
                chk_exp = exp;
                chk_req = 1'b1;
                next_drive_point();
                chk_req = 1'b0;
        endtask

        task automatic read_end();
                aec = 1'b0;
                ce = 1'b1;
                next_drive_point();
        endtask

        task automatic read_check(input logic [5:0] addr);
                logic [7:0] exp;
                read_start(addr, exp);
                next_drive_point();
                next_drive_point();
                check_dbo(addr, exp);
                read_end();
        endtask

        task automatic check_x_bit8();
                for (int n = 0; n < 8; n++) begin
                        check_value($sformatf("sprite_cfg.x[%0d][8]", n),
                                    {7'b0, sprite_cfg.x[n][8]}, {7'b0, shadow_regs[16][n]});
                end
        endtask

        // even addresses hold x low bytes, odd ones y
        task automatic compare_cfg_outputs();
                for (int n = 0; n < 8; n++) begin
                        check_value($sformatf("sprite_cfg.x[%0d][7:0]", n),
                                    sprite_cfg.x[n][7:0], shadow_regs[2*n]);
                        check_value($sformatf("sprite_cfg.y[%0d]", n),
                                    sprite_cfg.y[n], shadow_regs[2*n+1]);
                end
                check_value("screen_cfg.raster_irq_compare[7:0]",
                            screen_cfg.raster_irq_compare[7:0], shadow_regs[6'h12]);
                check_value("screen_cfg.raster_irq_compare[8]",
                            {7'b0, screen_cfg.raster_irq_compare[8]},
                            {7'b0, shadow_regs[6'h11][7]});
                check_value("irq_cfg", {5'b0, irq_cfg.emmc, irq_cfg.embc, irq_cfg.erst},
                            {5'b0, shadow_regs[6'h1a][2:0]});
        endtask

        task automatic clear_pulse_check(input logic [2:0] sel);
                bus_write(6'h19, {5'b0, sel});
                check_value("irst_clr/imbc_clr/immc_clr", {5'b0, immc_clr, imbc_clr, irst_clr},
                            {5'b0, sel});
                wait_for_phase(at_high_15, "phi_phase_start_15 in the high phase");
                #5;
                check_value("irst_clr/imbc_clr/immc_clr after release",
                            {5'b0, immc_clr, imbc_clr, irst_clr}, 8'h00);
                next_drive_point();
        endtask

        task automatic collision_check(input logic [5:0] addr);
                logic [7:0] exp;
                read_start(addr, exp);
                next_drive_point();
                check_value("collision clear", {7'b0, addr[0] ? m2d_clr : m2m_clr}, 8'h01);
                wait_for_phase(at_low_1, "phi_phase_start_1 in the low phase");
                #5;
                check_value("collision clear after release", {7'b0, m2m_clr | m2d_clr}, 8'h00);
                check_dbo(addr, exp);
                read_end();
        endtask

        initial begin
                logic [7:0] held;
                seed_val = $urandom(69551);
                error_count = 0;
                rst = 1'b1;
                aec = 1'b0;
                ce = 1'b1;
                rw = 1'b1;
                adi.raw = '0;
                dbi = '0;
                raster_line = '0;
                irq = 1'b0;
                immc = 1'b0;
                imbc = 1'b0;
                irst = 1'b0;
                sprite_m2m = '0;
                sprite_m2d = '0;
                chk_req = 1'b0;
                chk_addr = '0;
                chk_exp = '0;
                repeat (8) @(posedge clk_dot4x);
                #5;
                rst = 1'b0;
                next_drive_point();
                for (int pass = 0; pass < 2; pass++) begin
                        for (int a = 0; a < 47; a++) begin
                                if (a != 'h19) begin
                                        bus_write(6'(a), 8'($urandom));
                                end
                        end
                        check_x_bit8();
                        compare_cfg_outputs();
                        raster_line = 9'($urandom);
                        {irq, immc, imbc, irst} = 4'($urandom);
                        sprite_m2m = 8'($urandom);
                        sprite_m2d = 8'($urandom);
                        for (int a = 0; a < 64; a++) begin
                                read_check(6'(a));
                        end
                end
                clear_pulse_check(3'b101);
                clear_pulse_check(3'b010);
                collision_check(6'h1e);
                collision_check(6'h1f);
                // collision input moves while one read is held
                read_start(6'h1e, held);
                next_drive_point();
                sprite_m2m = ~sprite_m2m;
                next_drive_point();
                check_dbo(6'h1e, held);
                read_end();
                read_check(6'h1e);
                if (error_count == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

/* verilog.f */
+incdir+testbench
common/vic_regs_pkg.sv
hdl/bus_cycle.sv
sprite/sprite_regs.sv
hdl/screen_regs.sv
hdl/irq_regs.sv
hdl/read_data.sv
hdl/vic_registers.sv
testbench/tb_vic_registers.sv
